/* sources.f */
logic/pipe_pkg.sv
logic/stage_register.sv
logic/fetch_unit.sv
logic/decode_unit.sv
logic/register_file.sv
logic/execute_unit.sv
logic/hazard_unit.sv
logic/pipeline_core.sv
verif/pipeline_core_tb.sv

/* Bender.yml */
package:
  name: pipeline_core

sources:
  - logic/pipe_pkg.sv
  - logic/stage_register.sv
  - logic/fetch_unit.sv
  - logic/decode_unit.sv
  - logic/register_file.sv
  - logic/execute_unit.sv
  - logic/hazard_unit.sv
  - logic/pipeline_core.sv
  - target: test
    files:
      - verif/pipeline_core_tb.sv

/* verif/pipeline_core_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module pipeline_core_tb;

  localparam pipe_pkg::data_t RESET_PC = 32'h0000_0040;
  localparam int TIMEOUT_CYCLES = 400;

  logic               clk;
  logic               rst_n;
  pipe_pkg::data_t    imem_addr;
  pipe_pkg::data_t    imem_data;
  pipe_pkg::data_t    dmem_addr;
  pipe_pkg::data_t    dmem_wdata;
  logic               dmem_write;
  logic               dmem_read;
  pipe_pkg::data_t    dmem_rdata;
  logic               retire_valid;
  pipe_pkg::reg_idx_t retire_dest;
  pipe_pkg::data_t    retire_data;

  pipe_pkg::data_t    imem [1024];
  pipe_pkg::data_t    dmem [256];
  pipe_pkg::data_t    model_dmem [256];
  pipe_pkg::data_t    prog [$];
  pipe_pkg::reg_idx_t exp_dest [$];
  pipe_pkg::data_t    exp_data [$];
  pipe_pkg::data_t    exp_st_addr [$];
  pipe_pkg::data_t    exp_st_data [$];
  pipe_pkg::data_t    exp_ld_addr [$];
  int                 errors;
  logic [31:0]        lcg_state;

  pipeline_core #(.reset_pc(RESET_PC)) dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .imem_addr   (imem_addr),
    .imem_data   (imem_data),
    .dmem_addr   (dmem_addr),
    .dmem_wdata  (dmem_wdata),
    .dmem_write  (dmem_write),
    .dmem_read   (dmem_read),
    .dmem_rdata  (dmem_rdata),
    .retire_valid(retire_valid),
    .retire_dest (retire_dest),
    .retire_data (retire_data)
  );

  always #10 clk = ~clk;

  // outside the program area the fetch sees zero, which decodes as a nop.
  assign imem_data  = (imem_addr < 32'h1000) ? imem[imem_addr[11:2]] : '0;
  assign dmem_rdata = dmem[dmem_addr[9:2]];

  always @(posedge clk) begin
    if (dmem_write) begin
      dmem[dmem_addr[9:2]] <= dmem_wdata;
    end
  end

  task automatic check_data(input string name, input pipe_pkg::data_t got,
                            input pipe_pkg::data_t exp);
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_reg_idx(input string name, input pipe_pkg::reg_idx_t got,
                               input pipe_pkg::reg_idx_t exp);
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  // retirements, stores and loads are checked in program order.
  always @(negedge clk) begin
    if (retire_valid === 1'b1) begin
      if (exp_dest.size() == 0) begin
        errors++;
        $display("ERROR: at %0t r%0d retired but no retirement was expected", $time,
                 retire_dest);
      end else begin
        check_reg_idx("retire_dest", retire_dest, exp_dest.pop_front());
        check_data("retire_data", retire_data, exp_data.pop_front());
      end
    end
    if (dmem_write === 1'b1) begin
      if (exp_st_addr.size() == 0) begin
        errors++;
        $display("ERROR: at %0t a store to %h was seen but none was expected", $time,
                 dmem_addr);
      end else begin
        check_data("dmem_addr", dmem_addr, exp_st_addr.pop_front());
        check_data("dmem_wdata", dmem_wdata, exp_st_data.pop_front());
      end
    end
    if (dmem_read === 1'b1) begin
      if (exp_ld_addr.size() == 0) begin
        errors++;
        $display("ERROR: at %0t a load from %h was seen but none was expected", $time,
                 dmem_addr);
      end else begin
        check_data("dmem_addr", dmem_addr, exp_ld_addr.pop_front());
      end
    end
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return {16'd0, lcg_state[31:16]};
  endfunction

  function automatic pipe_pkg::data_t fill_word(input int idx);
    logic [31:0] addr;
    addr = idx * 4;
    return (addr * 32'h9E37_79B1) ^ 32'h5A5A_0000;
  endfunction

  function automatic int outstanding();
    return exp_dest.size() + exp_st_addr.size() + exp_ld_addr.size();
  endfunction

  function automatic pipe_pkg::data_t rr_instr(input pipe_pkg::reg_idx_t rd,
                                               input pipe_pkg::reg_idx_t rs,
                                               input pipe_pkg::reg_idx_t rt,
                                               input logic [5:0] fn);
    return {pipe_pkg::OP_RTYPE, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic pipe_pkg::data_t imm_instr(input logic [5:0] op,
                                                input pipe_pkg::reg_idx_t rt,
                                                input pipe_pkg::reg_idx_t rs,
                                                input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  // instruction-level model of the loaded program.
  task automatic run_model();
    pipe_pkg::data_t    regs [32];
    pipe_pkg::data_t    pc;
    pipe_pkg::data_t    next_pc;
    pipe_pkg::data_t    instr;
    pipe_pkg::data_t    a;
    pipe_pkg::data_t    b;
    pipe_pkg::data_t    imm;
    pipe_pkg::data_t    addr;
    pipe_pkg::data_t    res;
    pipe_pkg::reg_idx_t dest;
    logic               wr;
    int                 steps;
    for (int i = 0; i < 32; i++) begin
      regs[i] = '0;
    end
    pc = RESET_PC;
    steps = 0;
    while ((pc - RESET_PC) < 4 * prog.size() && steps < 1000) begin
      instr   = prog[(pc - RESET_PC) >> 2];
      imm     = {{16{instr[15]}}, instr[15:0]};
      a       = regs[instr[25:21]];
      b       = regs[instr[20:16]];
      addr    = a + imm;
      dest    = instr[20:16];
      next_pc = pc + 4;
      wr      = 1'b0;
      res     = '0;
      case (instr[31:26])
        pipe_pkg::OP_RTYPE: begin
          dest = instr[15:11];
          wr   = 1'b1;
          case (instr[5:0])
            pipe_pkg::FN_ADD: res = a + b;
            pipe_pkg::FN_SUB: res = a - b;
            pipe_pkg::FN_AND: res = a & b;
            pipe_pkg::FN_OR:  res = a | b;
            pipe_pkg::FN_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default:          wr = 1'b0;
          endcase
        end
        pipe_pkg::OP_ADDI: begin
          res = a + imm;
          wr  = 1'b1;
        end
        pipe_pkg::OP_LW: begin
          res = model_dmem[addr[9:2]];
          wr  = 1'b1;
          exp_ld_addr.push_back(addr);
        end
        pipe_pkg::OP_SW: begin
          model_dmem[addr[9:2]] = b;
          exp_st_addr.push_back(addr);
          exp_st_data.push_back(b);
        end
        pipe_pkg::OP_BEQ: begin
          if (a == b) begin
            next_pc = pc + 4 + (imm << 2);
          end
        end
        default: ;
      endcase
      // r0 writes still retire but the register stays zero.
      if (wr) begin
        exp_dest.push_back(dest);
        exp_data.push_back(res);
        if (dest != 0) begin
          regs[dest] = res;
        end
      end
      pc = next_pc;
      steps++;
    end
  endtask

  task automatic run_program(input string name);
    int cycles;
    rst_n = 1'b0;
    exp_dest.delete();
    exp_data.delete();
    exp_st_addr.delete();
    exp_st_data.delete();
    exp_ld_addr.delete();
    for (int i = 0; i < 1024; i++) begin
      imem[i] = '0;
    end
    for (int i = 0; i < prog.size(); i++) begin
      imem[(RESET_PC >> 2) + i] = prog[i];
    end
    for (int i = 0; i < 256; i++) begin
      dmem[i]       = fill_word(i);
      model_dmem[i] = dmem[i];
    end
    run_model();
    repeat (8) @(posedge clk);
    #2;
    rst_n = 1'b1;
    check_data("imem_addr", imem_addr, RESET_PC);
    // first fetch reaches memory on the third edge and writeback on the fourth.
    repeat (3) begin
      @(negedge clk);
      check_bit("retire_valid", retire_valid, 1'b0);
      check_bit("dmem_write", dmem_write, 1'b0);
      check_bit("dmem_read", dmem_read, 1'b0);
    end
    cycles = 0;
    while (outstanding() != 0 && cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    if (outstanding() != 0) begin
      errors++;
      $display("ERROR: %s timed out with %0d retirements, %0d stores and %0d loads missing",
               name, exp_dest.size(), exp_st_addr.size(), exp_ld_addr.size());
    end
    // idle cycles catch anything that retires late.
    repeat (10) @(posedge clk);
    #2;
  endtask

  task automatic alu_independent();
    prog.delete();
    prog.push_back(imm_instr(pipe_pkg::OP_ADDI, 1, 0, 5));
    prog.push_back(imm_instr(pipe_pkg::OP_ADDI, 2, 0, -3));
    prog.push_back(imm_instr(pipe_pkg::OP_ADDI, 3, 0, 16'h7fff));
    prog.push_back(imm_instr(pipe_pkg::OP_ADDI, 5, 0, -100));
    prog.push_back(rr_instr(6, 1, 2, pipe_pkg::FN_ADD));
    prog.push_back(rr_instr(7, 3, 5, pipe_pkg::FN_SUB));
    prog.push_back(rr_instr(8, 1, 3, pipe_pkg::FN_AND));
    prog.push_back(rr_instr(9, 2, 5, pipe_pkg::FN_OR));
    prog.push_back(rr_instr(10, 2, 1, pipe_pkg::FN_SLT));
    prog.push_back(rr_instr(11, 1, 2, pipe_pkg::FN_SLT));
    prog.push_back(imm_instr(pipe_pkg::OP_ADDI, 0, 0, 55));
    prog.push_back(rr_instr(12, 0, 1, pipe_pkg::FN_ADD));
    run_program("independent alu");
  endtask

  task automatic dependent_chain();
    prog.delete();
    prog.push_back(imm_instr(pipe_pkg::OP_ADDI, 1, 0, 7));
    prog.push_back(rr_instr(2, 1, 1, pipe_pkg::FN_ADD));
    prog.push_back(imm_instr(pipe_pkg::OP_ADDI, 3, 0, -4));
    prog.push_back(imm_instr(pipe_pkg::OP_ADDI, 9, 0, 1));
    prog.push_back(rr_instr(4, 3, 2, pipe_pkg::FN_ADD));
    prog.push_back(imm_instr(pipe_pkg::OP_ADDI, 5, 0, 20));
    prog.push_back(imm_instr(pipe_pkg::OP_ADDI, 9, 0, 2));
    prog.push_back(imm_instr(pipe_pkg::OP_ADDI, 10, 0, 3));
    prog.push_back(rr_instr(6, 5, 4, pipe_pkg::FN_SUB));
    prog.push_back(rr_instr(7, 6, 2, pipe_pkg::FN_OR));
    prog.push_back(rr_instr(8, 7, 3, pipe_pkg::FN_SLT));
    run_program("dependent chain");
  endtask

  task automatic store_load();
    prog.delete();
    prog.push_back(imm_instr(pipe_pkg::OP_ADDI, 1, 0, 16'h1234));
    prog.push_back(imm_instr(pipe_pkg::OP_ADDI, 2, 0, 16'h0100));
    prog.push_back(imm_instr(pipe_pkg::OP_SW, 1, 2, 0));
    prog.push_back(imm_instr(pipe_pkg::OP_LW, 3, 2, 0));
    prog.push_back(rr_instr(4, 3, 3, pipe_pkg::FN_ADD));
    prog.push_back(imm_instr(pipe_pkg::OP_SW, 4, 2, 8));
    prog.push_back(imm_instr(pipe_pkg::OP_LW, 5, 2, 8));
    prog.push_back(imm_instr(pipe_pkg::OP_LW, 6, 2, 4));
    run_program("store then load");
  endtask

  task automatic beq_paths();
    prog.delete();
    prog.push_back(imm_instr(pipe_pkg::OP_ADDI, 1, 0, 3));
    prog.push_back(imm_instr(pipe_pkg::OP_ADDI, 2, 0, 3));
    prog.push_back(imm_instr(pipe_pkg::OP_BEQ, 2, 1, 2));
    prog.push_back(imm_instr(pipe_pkg::OP_ADDI, 3, 0, 111));
    prog.push_back(imm_instr(pipe_pkg::OP_ADDI, 4, 0, 222));
    prog.push_back(imm_instr(pipe_pkg::OP_ADDI, 5, 0, 5));
    prog.push_back(imm_instr(pipe_pkg::OP_BEQ, 5, 1, 1));
    prog.push_back(imm_instr(pipe_pkg::OP_ADDI, 6, 0, 66));
    prog.push_back(imm_instr(pipe_pkg::OP_ADDI, 7, 0, 77));
    run_program("branch");
  endtask

  task automatic random_program();
    logic [5:0]         fns [5];
    pipe_pkg::reg_idx_t rd;
    pipe_pkg::reg_idx_t rs;
    pipe_pkg::reg_idx_t rt;
    logic [15:0]        offset;
    int                 kind;
    fns = '{pipe_pkg::FN_ADD, pipe_pkg::FN_SUB, pipe_pkg::FN_AND, pipe_pkg::FN_OR,
            pipe_pkg::FN_SLT};
    prog.delete();
    for (int i = 0; i < 40; i++) begin
      kind   = lcg_next() % 8;
      rd     = 5'(lcg_next() % 8);
      rs     = 5'(lcg_next() % 8);
      rt     = 5'(lcg_next() % 8);
      offset = 16'(32'h0100 + 4 * (lcg_next() % 32));
      if (kind < 4) begin
        prog.push_back(rr_instr(rd, rs, rt, fns[lcg_next() % 5]));
      end else if (kind < 6) begin
        prog.push_back(imm_instr(pipe_pkg::OP_ADDI, rt, rs, 16'(lcg_next())));
      end else if (kind == 6) begin
        prog.push_back(imm_instr(pipe_pkg::OP_LW, rt, 0, offset));
      end else begin
        prog.push_back(imm_instr(pipe_pkg::OP_SW, rt, 0, offset));
      end
    end
    run_program("random program");
  endtask

  initial begin
    clk       = 1'b0;
    rst_n     = 1'b0;
    errors    = 0;
    lcg_state = 32'd36;
    alu_independent();
    dependent_chain();
    store_load();
    beq_paths();
    random_program();
    $display("checks finished with %0d errors", errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* logic/pipeline_core.sv */
`timescale 1ns/1ns
`default_nettype none

module pipeline_core #(
  parameter pipe_pkg::data_t reset_pc = '0
) (
  input  wire logic          clk,
  input  wire logic          rst_n,
  output pipe_pkg::data_t    imem_addr,
  input  pipe_pkg::data_t    imem_data,
  output pipe_pkg::data_t    dmem_addr,
  output pipe_pkg::data_t    dmem_wdata,
  output logic               dmem_write,
  output logic               dmem_read,
  input  pipe_pkg::data_t    dmem_rdata,
  output logic               retire_valid,
  output pipe_pkg::reg_idx_t retire_dest,
  output pipe_pkg::data_t    retire_data
);

  pipe_pkg::data_t    pc;
  pipe_pkg::data_t    branch_target;
  logic               branch_taken;
  logic               stall;
  logic               flush_if_id;
  logic               flush_id_ex;
  logic               uses_rt;
  logic               wb_en;
  pipe_pkg::reg_idx_t rs_idx;
  pipe_pkg::reg_idx_t rt_idx;
  pipe_pkg::data_t    rs_data;
  pipe_pkg::data_t    rt_data;

  pipe_pkg::if_id_t   if_id_d;
  pipe_pkg::if_id_t   if_id_q;
  pipe_pkg::id_ex_t   id_ex_d;
  pipe_pkg::id_ex_t   id_ex_q;
  pipe_pkg::ex_mem_t  ex_mem_d;
  pipe_pkg::ex_mem_t  ex_mem_q;
  pipe_pkg::mem_wb_t  mem_wb_d;
  pipe_pkg::mem_wb_t  mem_wb_q;

  fetch_unit #(.reset_pc(reset_pc)) fetch (
    .clk          (clk),
    .rst_n        (rst_n),
    .stall        (stall),
    .branch_taken (branch_taken),
    .branch_target(branch_target),
    .pc           (pc),
    .imem_addr    (imem_addr)
  );

  // instruction memory answers in the same cycle.
  assign if_id_d = '{valid: 1'b1, pc: pc, instr: imem_data};

  stage_register #(.payload_t(pipe_pkg::if_id_t)) if_id_reg (
    .clk  (clk),
    .rst_n(rst_n),
    .stall(stall),
    .flush(flush_if_id),
    .d    (if_id_d),
    .q    (if_id_q)
  );

  decode_unit decode (
    .if_id  (if_id_q),
    .rs_data(rs_data),
    .rt_data(rt_data),
    .rs_idx (rs_idx),
    .rt_idx (rt_idx),
    .uses_rt(uses_rt),
    .id_ex  (id_ex_d)
  );

  register_file regs (
    .clk    (clk),
    .rst_n  (rst_n),
    .rs_idx (rs_idx),
    .rt_idx (rt_idx),
    .rs_data(rs_data),
    .rt_data(rt_data),
    .wr_en  (wb_en),
    .wr_idx (mem_wb_q.dest),
    .wr_data(mem_wb_q.result)
  );

  hazard_unit hazards (
    .rs_idx      (rs_idx),
    .rt_idx      (rt_idx),
    .uses_rt     (uses_rt),
    .id_ex       (id_ex_q),
    .ex_mem      (ex_mem_q),
    .branch_taken(branch_taken),
    .stall       (stall),
    .flush_if_id (flush_if_id),
    .flush_id_ex (flush_id_ex)
  );

  // a stall leaves a bubble in id/ex.
  stage_register #(.payload_t(pipe_pkg::id_ex_t)) id_ex_reg (
    .clk  (clk),
    .rst_n(rst_n),
    .stall(1'b0),
    .flush(flush_id_ex),
    .d    (id_ex_d),
    .q    (id_ex_q)
  );

  execute_unit execute (
    .id_ex        (id_ex_q),
    .ex_mem       (ex_mem_d),
    .branch_taken (branch_taken),
    .branch_target(branch_target)
  );

  stage_register #(.payload_t(pipe_pkg::ex_mem_t)) ex_mem_reg (
    .clk  (clk),
    .rst_n(rst_n),
    .stall(1'b0),
    .flush(1'b0),
    .d    (ex_mem_d),
    .q    (ex_mem_q)
  );

  // memory stage.
  assign dmem_addr  = ex_mem_q.alu_result;
  assign dmem_wdata = ex_mem_q.store_data;
  assign dmem_write = ex_mem_q.valid && ex_mem_q.mem_write;
  assign dmem_read  = ex_mem_q.valid && ex_mem_q.mem_read;

  assign mem_wb_d = '{
    valid:     ex_mem_q.valid,
    result:    ex_mem_q.mem_read ? dmem_rdata : ex_mem_q.alu_result,
    dest:      ex_mem_q.dest,
    reg_write: ex_mem_q.reg_write
  };

  stage_register #(.payload_t(pipe_pkg::mem_wb_t)) mem_wb_reg (
    .clk  (clk),
    .rst_n(rst_n),
    .stall(1'b0),
    .flush(1'b0),
    .d    (mem_wb_d),
    .q    (mem_wb_q)
  );

  // writeback and retire.
  assign wb_en        = mem_wb_q.valid && mem_wb_q.reg_write;
  assign retire_valid = wb_en;
  assign retire_dest  = mem_wb_q.dest;
  assign retire_data  = mem_wb_q.result;

  // a dependent instruction waits at most two cycles.
  stall_at_most_two: assert property (
    @(posedge clk) disable iff (!rst_n) stall [*2] |=> !stall
  );

endmodule

`default_nettype wire

/* logic/hazard_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module hazard_unit (
  input  pipe_pkg::reg_idx_t rs_idx,
  input  pipe_pkg::reg_idx_t rt_idx,
  input  wire logic          uses_rt,
  input  pipe_pkg::id_ex_t   id_ex,
  input  pipe_pkg::ex_mem_t  ex_mem,
  input  wire logic          branch_taken,
  output logic               stall,
  output logic               flush_if_id,
  output logic               flush_id_ex
);

  logic raw_hazard;

  function automatic logic pending_write(input logic v, input logic we,
                                         input pipe_pkg::reg_idx_t dest,
                                         input pipe_pkg::reg_idx_t src);
    return v && we && (dest != '0) && (dest == src);
  endfunction

  // writers in mem/wb are covered by register file write-through.
  assign raw_hazard =
    pending_write(id_ex.valid, id_ex.reg_write, id_ex.dest, rs_idx) ||
    pending_write(ex_mem.valid, ex_mem.reg_write, ex_mem.dest, rs_idx) ||
    (uses_rt && (pending_write(id_ex.valid, id_ex.reg_write, id_ex.dest, rt_idx) ||
                 pending_write(ex_mem.valid, ex_mem.reg_write, ex_mem.dest, rt_idx)));

  assign stall       = raw_hazard && !branch_taken;
  assign flush_if_id = branch_taken;
  assign flush_id_ex = branch_taken || stall;

endmodule

`default_nettype wire

/* logic/execute_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module execute_unit (
  input  pipe_pkg::id_ex_t  id_ex,
  output pipe_pkg::ex_mem_t ex_mem,
  output logic              branch_taken,
  output pipe_pkg::data_t   branch_target
);

  pipe_pkg::data_t op_a;
  pipe_pkg::data_t op_b;
  pipe_pkg::data_t alu_out;

  assign op_a = id_ex.rs_data;
  assign op_b = id_ex.alu_src_imm ? id_ex.imm : id_ex.rt_data;

  always_comb begin
    case (id_ex.alu_op)
      pipe_pkg::ALU_SUB: alu_out = op_a - op_b;
      pipe_pkg::ALU_AND: alu_out = op_a & op_b;
      pipe_pkg::ALU_OR:  alu_out = op_a | op_b;
      pipe_pkg::ALU_SLT: alu_out = {31'd0, $signed(op_a) < $signed(op_b)};
      default:           alu_out = op_a + op_b;
    endcase
  end

  assign branch_taken  = id_ex.valid && id_ex.branch && (id_ex.rs_data == id_ex.rt_data);
  assign branch_target = id_ex.pc + 32'd4 + {id_ex.imm[29:0], 2'b00};

  always_comb begin
    ex_mem            = '0;
    ex_mem.valid      = id_ex.valid;
    ex_mem.alu_result = alu_out;
    ex_mem.store_data = id_ex.rt_data;
    ex_mem.dest       = id_ex.dest;
    ex_mem.mem_read   = id_ex.mem_read;
    ex_mem.mem_write  = id_ex.mem_write;
    ex_mem.reg_write  = id_ex.reg_write;
  end

endmodule

`default_nettype wire

/* logic/register_file.sv */
`timescale 1ns/1ns
`default_nettype none

module register_file (
  input  wire logic          clk,
  input  wire logic          rst_n,
  input  pipe_pkg::reg_idx_t rs_idx,
  input  pipe_pkg::reg_idx_t rt_idx,
  output pipe_pkg::data_t    rs_data,
  output pipe_pkg::data_t    rt_data,
  input  wire logic          wr_en,
  input  pipe_pkg::reg_idx_t wr_idx,
  input  pipe_pkg::data_t    wr_data
);

  pipe_pkg::data_t regs [32];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && (wr_idx != '0)) begin
      regs[wr_idx] <= wr_data;
    end
  end

  // same-cycle write is visible to decode.
  assign rs_data = (rs_idx == '0) ? '0 :
                   (wr_en && (wr_idx == rs_idx)) ? wr_data : regs[rs_idx];
  assign rt_data = (rt_idx == '0) ? '0 :
                   (wr_en && (wr_idx == rt_idx)) ? wr_data : regs[rt_idx];

endmodule

`default_nettype wire

/* logic/decode_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module decode_unit (
  input  pipe_pkg::if_id_t   if_id,
  input  pipe_pkg::data_t    rs_data,
  input  pipe_pkg::data_t    rt_data,
  output pipe_pkg::reg_idx_t rs_idx,
  output pipe_pkg::reg_idx_t rt_idx,
  output logic               uses_rt,
  output pipe_pkg::id_ex_t   id_ex
);

  logic [5:0]         opcode;
  logic [5:0]         funct;
  pipe_pkg::reg_idx_t rd_idx;

  assign opcode = if_id.instr[31:26];
  assign funct  = if_id.instr[5:0];
  assign rs_idx = if_id.instr[25:21];
  assign rt_idx = if_id.instr[20:16];
  assign rd_idx = if_id.instr[15:11];

  // rt is a source for r-type, sw and beq only.
  assign uses_rt = (opcode == pipe_pkg::OP_RTYPE) || (opcode == pipe_pkg::OP_SW) ||
                   (opcode == pipe_pkg::OP_BEQ);

  always_comb begin
    id_ex         = '0;
    id_ex.valid   = if_id.valid;
    id_ex.pc      = if_id.pc;
    id_ex.rs_data = rs_data;
    id_ex.rt_data = rt_data;
    id_ex.imm     = {{16{if_id.instr[15]}}, if_id.instr[15:0]};
    case (opcode)
      pipe_pkg::OP_RTYPE: begin
        id_ex.dest      = rd_idx;
        id_ex.reg_write = 1'b1;
        case (funct)
          pipe_pkg::FN_ADD: id_ex.alu_op = pipe_pkg::ALU_ADD;
          pipe_pkg::FN_SUB: id_ex.alu_op = pipe_pkg::ALU_SUB;
          pipe_pkg::FN_AND: id_ex.alu_op = pipe_pkg::ALU_AND;
          pipe_pkg::FN_OR:  id_ex.alu_op = pipe_pkg::ALU_OR;
          pipe_pkg::FN_SLT: id_ex.alu_op = pipe_pkg::ALU_SLT;
          default:          id_ex.reg_write = 1'b0;
        endcase
      end
      pipe_pkg::OP_ADDI: begin
        id_ex.dest        = rt_idx;
        id_ex.alu_src_imm = 1'b1;
        id_ex.reg_write   = 1'b1;
      end
      pipe_pkg::OP_LW: begin
        id_ex.dest        = rt_idx;
        id_ex.alu_src_imm = 1'b1;
        id_ex.mem_read    = 1'b1;
        id_ex.reg_write   = 1'b1;
      end
      pipe_pkg::OP_SW: begin
        id_ex.alu_src_imm = 1'b1;
        id_ex.mem_write   = 1'b1;
      end
      pipe_pkg::OP_BEQ: begin
        id_ex.alu_op = pipe_pkg::ALU_SUB;
        id_ex.branch = 1'b1;
      end
      // unknown opcode passes as a harmless valid entry.
      default: ;
    endcase
    if (!if_id.valid) begin
      id_ex.reg_write = 1'b0;
      id_ex.mem_read  = 1'b0;
      id_ex.mem_write = 1'b0;
      id_ex.branch    = 1'b0;
    end
  end

endmodule

`default_nettype wire

/* logic/fetch_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_unit #(
  parameter pipe_pkg::data_t reset_pc = '0
) (
  input  wire logic       clk,
  input  wire logic       rst_n,
  input  wire logic       stall,
  input  wire logic       branch_taken,
  input  pipe_pkg::data_t branch_target,
  output pipe_pkg::data_t pc,
  output pipe_pkg::data_t imem_addr
);

  // a taken branch wins over a decode stall.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= reset_pc;
    end else if (branch_taken) begin
      pc <= branch_target;
    end else if (!stall) begin
      pc <= pc + 32'd4;
    end
  end

  assign imem_addr = pc;

endmodule

`default_nettype wire

/* logic/stage_register.sv */
`timescale 1ns/1ns
`default_nettype none

module stage_register #(
  parameter type payload_t = pipe_pkg::if_id_t
) (
  input  wire logic clk,
  input  wire logic rst_n,
  input  wire logic stall,
  input  wire logic flush,
  input  payload_t  d,
  output payload_t  q
);

  // an all-zero payload is a bubble; flush beats stall.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      q <= '0;
    end else if (flush) begin
      q <= '0;
    end else if (!stall) begin
      q <= d;
    end
  end

  controls_known: assert property (
    @(posedge clk) disable iff (!rst_n) !$isunknown({stall, flush})
  );

endmodule

`default_nettype wire

/* logic/pipe_pkg.sv */
`default_nettype none

package pipe_pkg;

  typedef logic [31:0] data_t;
  typedef logic [4:0]  reg_idx_t;

  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_SLT = 3'd4
  } alu_op_e;

  // primary opcodes.
  localparam logic [5:0] OP_RTYPE = 6'h00;
  localparam logic [5:0] OP_BEQ   = 6'h04;
  localparam logic [5:0] OP_ADDI  = 6'h08;
  localparam logic [5:0] OP_LW    = 6'h23;
  localparam logic [5:0] OP_SW    = 6'h2b;

  // r-type funct field.
  localparam logic [5:0] FN_ADD = 6'h20;
  localparam logic [5:0] FN_SUB = 6'h22;
  localparam logic [5:0] FN_AND = 6'h24;
  localparam logic [5:0] FN_OR  = 6'h25;
  localparam logic [5:0] FN_SLT = 6'h2a;

  typedef struct packed {
    logic  valid;
    data_t pc;
    data_t instr;
  } if_id_t;

  typedef struct packed {
    logic     valid;
    data_t    pc;
    data_t    rs_data;
    data_t    rt_data;
    data_t    imm;
    reg_idx_t dest;
    alu_op_e  alu_op;
    logic     alu_src_imm;
    logic     mem_read;
    logic     mem_write;
    logic     reg_write;
    logic     branch;
  } id_ex_t;

  typedef struct packed {
    logic     valid;
    data_t    alu_result;
    data_t    store_data;
    reg_idx_t dest;
    logic     mem_read;
    logic     mem_write;
    logic     reg_write;
  } ex_mem_t;

  typedef struct packed {
    logic     valid;
    data_t    result;
    reg_idx_t dest;
    logic     reg_write;
  } mem_wb_t;

endpackage

`default_nettype wire
